//--- include/comms_params.svh
// Link status subsystem parameters
//   Read and write register address map
//   ID words and unmapped read value
//   LOS watchdog timeout and expected protocol version

`ifndef COMMS_PARAMS_SVH
`define COMMS_PARAMS_SVH

// Read registers
`define COMMS_INFO0_ADDR       0
`define COMMS_INFO1_ADDR       1
`define COMMS_FRAME_CNT_ADDR   2
`define COMMS_LATENCY_ADDR     3
`define COMMS_FAULT_ADDR       4
`define COMMS_FAULT_CNT_ADDR   5
`define COMMS_LOS_ADDR         6
`define COMMS_PROTO_VER_ADDR   7
`define COMMS_GW_TYPE_ADDR     8
`define COMMS_LOCATION_ADDR    9
`define COMMS_REV_ID_ADDR      10
`define COMMS_NUM_RD_REG       11

// Write registers
`define COMMS_TX_LOCATION_ADDR 0
`define COMMS_FAULT_CLR_ADDR   1

// ASCII "LNK\n" and "STA\n"
`define COMMS_ID0              32'h4c4e_4b0a
`define COMMS_ID1              32'h5354_410a
`define COMMS_BAD_ADDR_DATA    32'hbad0_add0

`define COMMS_LOS_TIMEOUT      64
`define COMMS_PROTO_VER        4'h3

`endif

//--- verilog/lb_pkg.sv
// Local bus types
//   Word address, data word and read register index

`default_nettype none

package lb_pkg;

   // ------------------------------
   // Bus fields
   // ------------------------------

   // Word address, one register per address
   typedef logic [23:0] lb_addr_t;

   // Read and write data
   typedef logic [31:0] lb_data_t;

   // ------------------------------
   // Register bank
   // ------------------------------

   // Wide enough for the eleven read registers
   typedef logic [3:0] lb_reg_idx_t;

endpackage

`default_nettype wire

//--- verilog/comms_pkg.sv
// Link side types
//   Counter, sticky fault vector, partner header fields
//   Monitor state machine encoding

`default_nettype none

package comms_pkg;

   // Frame count, fault count and latency
   typedef logic [15:0] cnt16_t;

   // Sticky faults
   // bit 0 CRC error, bit 1 protocol version mismatch, bit 2 LOS event
   typedef logic [2:0] fault_t;

   // ------------------------------
   // Partner header fields
   // ------------------------------
   typedef logic [3:0]  proto_ver_t;
   typedef logic [2:0]  gw_type_t;
   typedef logic [2:0]  location_t;
   typedef logic [31:0] rev_id_t;

   // ------------------------------
   // Monitor FSM
   // ------------------------------
   typedef enum logic {
      LINK_DOWN = 1'b0,
      LINK_UP   = 1'b1
   } mon_state_t;

endpackage

`default_nettype wire

//--- verilog/link_status_if.sv
// Status bundle between the frame monitor and the register bank
//   Monitor drives counters, faults, LOS and partner header
//   Register bank drives the fault clear strobe

`default_nettype none

interface link_status_if import comms_pkg::*; ();

   // Monitor to regbank
   cnt16_t     frame_cnt;
   fault_t     fault;
   cnt16_t     fault_cnt;
   logic       los;
   proto_ver_t proto_ver;
   gw_type_t   gw_type;
   location_t  location;
   rev_id_t    rev_id;

   // Regbank to monitor, one cycle wide
   logic       fault_clr;

   modport monitor (
      output frame_cnt, fault, fault_cnt, los,
      output proto_ver, gw_type, location, rev_id,
      input  fault_clr
   );

   modport regbank (
      input  frame_cnt, fault, fault_cnt, los,
      input  proto_ver, gw_type, location, rev_id,
      output fault_clr
   );

endinterface

`default_nettype wire

//--- verilog/rx_frame_monitor.sv
// Received frame monitor
//   Good frame counter and partner header capture
//   CRC and protocol version faults, saturating fault counter
//   LOS watchdog with LINK_UP / LINK_DOWN FSM

`default_nettype none
`include "comms_params.svh"

module rx_frame_monitor import comms_pkg::*; (
   input  wire             lb_clk,
   input  wire             reset_i,
   input  wire             rx_frame_valid_i,
   input  wire             rx_crc_ok_i,
   input  wire proto_ver_t rx_protocol_ver_i,
   input  wire gw_type_t   rx_gateware_type_i,
   input  wire location_t  rx_location_i,
   input  wire rev_id_t    rx_rev_id_i,
   link_status_if.monitor  status
);

   localparam int WD_W = $clog2(`COMMS_LOS_TIMEOUT);
   localparam logic [WD_W-1:0] WD_LAST = WD_W'(`COMMS_LOS_TIMEOUT - 1);

   mon_state_t      state;
   logic [WD_W-1:0] wd_cnt;
   cnt16_t          frame_cnt_q;
   cnt16_t          fault_cnt_q;
   cnt16_t          fault_cnt_base;
   fault_t          fault_q;
   fault_t          fault_set;
   logic            good_frame;
   logic            bad_frame;
   logic            wd_expire;

   assign good_frame = rx_frame_valid_i && rx_crc_ok_i;
   assign bad_frame  = rx_frame_valid_i && !rx_crc_ok_i;

   // Timeout only counts while the link is up
   assign wd_expire = (state == LINK_UP) && !good_frame && (wd_cnt == WD_LAST);

   assign fault_set[0] = bad_frame;
   assign fault_set[1] = good_frame && (rx_protocol_ver_i != `COMMS_PROTO_VER);
   assign fault_set[2] = wd_expire;

   // Clear first, then any new event on top of it
   assign fault_cnt_base = status.fault_clr ? '0 : fault_cnt_q;

   // ------------------------------
   // Counters and faults
   // ------------------------------
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         frame_cnt_q <= '0;
         fault_cnt_q <= '0;
         fault_q     <= '0;
      end else begin
         if (good_frame)
            frame_cnt_q <= frame_cnt_q + 1'b1;
         if (bad_frame && (fault_cnt_base != 16'hffff))
            fault_cnt_q <= fault_cnt_base + 1'b1;
         else
            fault_cnt_q <= fault_cnt_base;
         fault_q <= (status.fault_clr ? '0 : fault_q) | fault_set;
      end
   end

   // Header of the latest good frame
   always_ff @(posedge lb_clk) begin
      if (good_frame) begin
         status.proto_ver <= rx_protocol_ver_i;
         status.gw_type   <= rx_gateware_type_i;
         status.location  <= rx_location_i;
         status.rev_id    <= rx_rev_id_i;
      end
   end

   // ------------------------------
   // LOS watchdog
   // ------------------------------
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         state  <= LINK_DOWN;
         wd_cnt <= '0;
      end else if (good_frame) begin
         state  <= LINK_UP;
         wd_cnt <= '0;
      end else if (wd_expire) begin
         state  <= LINK_DOWN;
         wd_cnt <= '0;
      end else if (state == LINK_UP) begin
         wd_cnt <= wd_cnt + 1'b1;
      end
   end

   assign status.los       = (state == LINK_DOWN);
   assign status.frame_cnt = frame_cnt_q;
   assign status.fault_cnt = fault_cnt_q;
   assign status.fault     = fault_q;

endmodule

`default_nettype wire

//--- verilog/latency_meter.sv
// Link round trip latency
//   Counts cycles from a sent marker frame to the next good received frame
//   Counter saturates, a new marker restarts it

`default_nettype none

module latency_meter import comms_pkg::*; (
   input  wire    lb_clk,
   input  wire    reset_i,
   input  wire    tx_marker_i,
   input  wire    rx_frame_valid_i,
   input  wire    rx_crc_ok_i,
   output cnt16_t latency_o
);

   logic   running;
   cnt16_t run_cnt;
   logic   good_frame;

   // Bad CRC frames do not count as a reply
   assign good_frame = rx_frame_valid_i && rx_crc_ok_i;

   // ------------------------------
   // Marker to reply counter
   // ------------------------------
   // run_cnt is 1 after the marker edge, so at the reply edge it
   // holds reply cycle minus marker cycle
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         running <= 1'b0;
         run_cnt <= '0;
      end else begin
         if (good_frame && running)
            running <= 1'b0;

         if (tx_marker_i) begin
            running <= 1'b1;
            run_cnt <= 16'd1;
         end else if (running && (run_cnt != 16'hffff)) begin
            run_cnt <= run_cnt + 1'b1;
         end
      end
   end

   // ------------------------------
   // Result register
   // ------------------------------
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         latency_o <= '0;
      end else if (good_frame && running) begin
         latency_o <= run_cnt;
      end
   end

endmodule

`default_nettype wire

//--- verilog/comms_top_regbank.sv
// Link status register bank
//   Per cycle snapshot of ID words and link status
//   Local bus read decode with one cycle read latency
//   tx_location write register and fault clear strobe

`default_nettype none
`include "comms_params.svh"

module comms_top_regbank import lb_pkg::*, comms_pkg::*; (
   input  wire            lb_clk,
   input  wire            reset_i,

   // Local bus
   input  wire            lb_valid_i,
   input  wire            lb_rnw_i,
   input  wire lb_addr_t  lb_addr_i,
   input  wire lb_data_t  lb_wdata_i,
   output lb_data_t       lb_rdata_o,

   // Status in, clear out
   link_status_if.regbank status,
   input  wire cnt16_t    latency_i,

   // Control out
   output location_t      tx_location_o
);

   lb_data_t    rd_array [`COMMS_NUM_RD_REG];
   lb_reg_idx_t rd_idx;
   logic        rd_hit;
   logic        wr_en;

   assign rd_idx = lb_reg_idx_t'(lb_addr_i);
   assign rd_hit = (lb_addr_i < lb_addr_t'(`COMMS_NUM_RD_REG));
   assign wr_en  = lb_valid_i && !lb_rnw_i;

   // ------------------------------
   // Status snapshot
   // ------------------------------
   // Narrow fields are zero extended to the bus width
   always_ff @(posedge lb_clk) begin
      rd_array[`COMMS_INFO0_ADDR]     <= `COMMS_ID0;
      rd_array[`COMMS_INFO1_ADDR]     <= `COMMS_ID1;
      rd_array[`COMMS_FRAME_CNT_ADDR] <= lb_data_t'(status.frame_cnt);
      rd_array[`COMMS_LATENCY_ADDR]   <= lb_data_t'(latency_i);
      rd_array[`COMMS_FAULT_ADDR]     <= lb_data_t'(status.fault);
      rd_array[`COMMS_FAULT_CNT_ADDR] <= lb_data_t'(status.fault_cnt);
      rd_array[`COMMS_LOS_ADDR]       <= lb_data_t'(status.los);
      rd_array[`COMMS_PROTO_VER_ADDR] <= lb_data_t'(status.proto_ver);
      rd_array[`COMMS_GW_TYPE_ADDR]   <= lb_data_t'(status.gw_type);
      rd_array[`COMMS_LOCATION_ADDR]  <= lb_data_t'(status.location);
      rd_array[`COMMS_REV_ID_ADDR]    <= lb_data_t'(status.rev_id);
   end

   // ------------------------------
   // Read decode
   // ------------------------------
   // Data holds until the next read
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         lb_rdata_o <= '0;
      end else if (lb_valid_i && lb_rnw_i) begin
         if (rd_hit)
            lb_rdata_o <= rd_array[rd_idx];
         else
            lb_rdata_o <= `COMMS_BAD_ADDR_DATA;
      end
   end

   // ------------------------------
   // Write registers
   // ------------------------------
   always_ff @(posedge lb_clk) begin
      if (reset_i) begin
         tx_location_o    <= '0;
         status.fault_clr <= 1'b0;
      end else begin
         if (wr_en && (lb_addr_i == lb_addr_t'(`COMMS_TX_LOCATION_ADDR)))
            tx_location_o <= location_t'(lb_wdata_i);

         // Any data value clears, strobe is high for one cycle
         status.fault_clr <= wr_en && (lb_addr_i == lb_addr_t'(`COMMS_FAULT_CLR_ADDR));
      end
   end

endmodule

`default_nettype wire

//--- verilog/comms_top.sv
// Link status subsystem top level
//   Frame monitor and latency meter feeding the register bank
//   Plain ports for the local bus and frame events

`default_nettype none

module comms_top import lb_pkg::*, comms_pkg::*; (
   input  wire             lb_clk,
   input  wire             reset_i,

   // Local bus
   input  wire             lb_valid_i,
   input  wire             lb_rnw_i,
   input  wire lb_addr_t   lb_addr_i,
   input  wire lb_data_t   lb_wdata_i,
   output lb_data_t        lb_rdata_o,

   // Decoded frame events
   input  wire             rx_frame_valid_i,
   input  wire             rx_crc_ok_i,
   input  wire proto_ver_t rx_protocol_ver_i,
   input  wire gw_type_t   rx_gateware_type_i,
   input  wire location_t  rx_location_i,
   input  wire rev_id_t    rx_rev_id_i,
   input  wire             tx_marker_i,

   // Control
   output location_t       tx_location_o
);

   cnt16_t latency;

   link_status_if status_if ();

   // ------------------------------
   // Link side
   // ------------------------------
   rx_frame_monitor u_rx_frame_monitor (
      .lb_clk             (lb_clk),
      .reset_i            (reset_i),
      .rx_frame_valid_i   (rx_frame_valid_i),
      .rx_crc_ok_i        (rx_crc_ok_i),
      .rx_protocol_ver_i  (rx_protocol_ver_i),
      .rx_gateware_type_i (rx_gateware_type_i),
      .rx_location_i      (rx_location_i),
      .rx_rev_id_i        (rx_rev_id_i),
      .status             (status_if.monitor)
   );

   latency_meter u_latency_meter (
      .lb_clk           (lb_clk),
      .reset_i          (reset_i),
      .tx_marker_i      (tx_marker_i),
      .rx_frame_valid_i (rx_frame_valid_i),
      .rx_crc_ok_i      (rx_crc_ok_i),
      .latency_o        (latency)
   );

   // ------------------------------
   // Bus side
   // ------------------------------
   comms_top_regbank u_regbank (
      .lb_clk        (lb_clk),
      .reset_i       (reset_i),
      .lb_valid_i    (lb_valid_i),
      .lb_rnw_i      (lb_rnw_i),
      .lb_addr_i     (lb_addr_i),
      .lb_wdata_i    (lb_wdata_i),
      .lb_rdata_o    (lb_rdata_o),
      .status        (status_if.regbank),
      .latency_i     (latency),
      .tx_location_o (tx_location_o)
   );

endmodule

`default_nettype wire

//--- verif/comms_top_assertions.sv
// Concurrent checks on the link status subsystem
//   Monitor side: LOS flag against the FSM, fault count only drops on clear
//   Regbank side: fault clear strobe is one cycle wide

`default_nettype none

module comms_top_assertions import comms_pkg::*; #(
   parameter bit MON_SIDE = 1'b1
) (
   input wire             lb_clk,
   input wire             reset_i,
   input wire mon_state_t state_i,
   input wire             los_i,
   input wire cnt16_t     fault_cnt_i,
   input wire             fault_clr_i
);

   if (MON_SIDE) begin : g_mon
      los_down_a : assert property (@(posedge lb_clk) disable iff (reset_i)
         los_i |-> (state_i == LINK_DOWN))
         else $error("los high while the monitor FSM is not in LINK_DOWN");

      // A lower count is only legal one cycle after the strobe
      fault_cnt_mono_a : assert property (@(posedge lb_clk) disable iff (reset_i)
         (fault_cnt_i < $past(fault_cnt_i)) |-> $past(fault_clr_i))
         else $error("fault_cnt decreased without a fault clear");
   end else begin : g_reg
      fault_clr_pulse_a : assert property (@(posedge lb_clk) disable iff (reset_i)
         fault_clr_i |=> !fault_clr_i)
         else $error("fault_clr held high for more than one cycle");
   end

endmodule

bind rx_frame_monitor comms_top_assertions #(.MON_SIDE(1'b1)) u_mon_assertions (
   .lb_clk      (lb_clk),
   .reset_i     (reset_i),
   .state_i     (state),
   .los_i       (status.los),
   .fault_cnt_i (fault_cnt_q),
   .fault_clr_i (status.fault_clr)
);

bind comms_top_regbank comms_top_assertions #(.MON_SIDE(1'b0)) u_reg_assertions (
   .lb_clk      (lb_clk),
   .reset_i     (reset_i),
   .state_i     (comms_pkg::LINK_DOWN),
   .los_i       (1'b0),
   .fault_cnt_i (16'h0),
   .fault_clr_i (status.fault_clr)
);

`default_nettype wire

//--- verif/comms_top_tb.sv
// Directed testbench for the link status subsystem
//   Clock, reset and cycle limit
//   Local bus, frame and marker drivers, compare task
//   ID, frame count, fault, LOS, latency and tx_location tests

`default_nettype none
`include "comms_params.svh"

module comms_top_tb import lb_pkg::*, comms_pkg::*; ();

   // Directed sequence is a few hundred cycles
   localparam int MAX_CYCLES = 3000;

   logic       lb_clk;
   logic       reset_i;
   logic       lb_valid_i;
   logic       lb_rnw_i;
   lb_addr_t   lb_addr_i;
   lb_data_t   lb_wdata_i;
   lb_data_t   lb_rdata_o;
   logic       rx_frame_valid_i;
   logic       rx_crc_ok_i;
   proto_ver_t rx_protocol_ver_i;
   gw_type_t   rx_gateware_type_i;
   location_t  rx_location_i;
   rev_id_t    rx_rev_id_i;
   logic       tx_marker_i;
   location_t  tx_location_o;

   // Reference model of the last good frame
   int         cycle_cnt = 0;
   cnt16_t     exp_frames;
   proto_ver_t last_ver;
   gw_type_t   last_gw;
   location_t  last_loc;
   rev_id_t    last_rev;

   comms_top DUT (.*);

   initial begin
      lb_clk = 1'b0;
      forever #5 lb_clk = ~lb_clk;
   end

   always @(posedge lb_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Simulation failed");
         $fatal(1, "Timeout, tests still running after %0d cycles", MAX_CYCLES);
      end
   end

   // ------------------------------
   // Drivers and compare
   // ------------------------------
   task automatic check_eq(input string name, input lb_data_t actual, input lb_data_t expected);
      if (actual !== expected) begin
         $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
         $display("Simulation failed");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge lb_clk);
   endtask

   task automatic lb_write(input int addr, input lb_data_t data);
      @(posedge lb_clk);
      lb_valid_i <= 1'b1;
      lb_rnw_i   <= 1'b0;
      lb_addr_i  <= lb_addr_t'(addr);
      lb_wdata_i <= data;
      @(posedge lb_clk);
      lb_valid_i <= 1'b0;
   endtask

   task automatic lb_read(input int addr, output lb_data_t data);
      @(posedge lb_clk);
      lb_valid_i <= 1'b1;
      lb_rnw_i   <= 1'b1;
      lb_addr_i  <= lb_addr_t'(addr);
      @(posedge lb_clk);
      lb_valid_i <= 1'b0;
      // Registered at this edge, stable by mid cycle
      @(negedge lb_clk);
      data = lb_rdata_o;
   endtask

   task automatic read_expect(input int addr, input lb_data_t expected, input string name);
      lb_data_t data;
      lb_read(addr, data);
      check_eq(name, data, expected);
   endtask

   // Frame is seen by the DUT at the second edge
   task automatic send_frame(input bit crc_ok, input proto_ver_t ver);
      gw_type_t  gw;
      location_t loc;
      rev_id_t   rev;
      gw  = gw_type_t'($urandom);
      loc = location_t'($urandom);
      rev = $urandom;
      @(posedge lb_clk);
      rx_frame_valid_i   <= 1'b1;
      rx_crc_ok_i        <= crc_ok;
      rx_protocol_ver_i  <= ver;
      rx_gateware_type_i <= gw;
      rx_location_i      <= loc;
      rx_rev_id_i        <= rev;
      @(posedge lb_clk);
      rx_frame_valid_i <= 1'b0;
      if (crc_ok) begin
         exp_frames = exp_frames + 16'd1;
         last_ver   = ver;
         last_gw    = gw;
         last_loc   = loc;
         last_rev   = rev;
      end
   endtask

   task automatic pulse_marker();
      @(posedge lb_clk);
      tx_marker_i <= 1'b1;
      @(posedge lb_clk);
      tx_marker_i <= 1'b0;
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------
   task automatic id_and_unmapped_reads();
      read_expect(`COMMS_INFO0_ADDR, `COMMS_ID0, "info0");
      read_expect(`COMMS_INFO1_ADDR, `COMMS_ID1, "info1");
      read_expect(`COMMS_NUM_RD_REG, `COMMS_BAD_ADDR_DATA, "unmapped 11");
      read_expect(32'h00ff_ffff, `COMMS_BAD_ADDR_DATA, "unmapped top");
   endtask

   task automatic los_watchdog();
      read_expect(`COMMS_LOS_ADDR, 32'h1, "los after reset");
      send_frame(1'b1, `COMMS_PROTO_VER);
      wait_cycles(2);
      read_expect(`COMMS_LOS_ADDR, 32'h0, "los after good frame");
      read_expect(`COMMS_FAULT_ADDR, 32'h0, "fault after good frame");
      // Still well inside the watchdog window
      wait_cycles(`COMMS_LOS_TIMEOUT - 16);
      read_expect(`COMMS_LOS_ADDR, 32'h0, "los before timeout");
      wait_cycles(`COMMS_LOS_TIMEOUT + 4);
      read_expect(`COMMS_LOS_ADDR, 32'h1, "los after timeout");
      read_expect(`COMMS_FAULT_ADDR, 32'h4, "fault after timeout");
   endtask

   task automatic frame_count_and_header();
      for (int i = 0; i < 8; i++) begin
         send_frame(1'b1, proto_ver_t'($urandom));
         // Bad frame must not replace the captured header
         if (i == 7)
            send_frame(1'b0, proto_ver_t'($urandom));
      end
      wait_cycles(2);
      read_expect(`COMMS_FRAME_CNT_ADDR, lb_data_t'(exp_frames), "frame_cnt");
      read_expect(`COMMS_PROTO_VER_ADDR, lb_data_t'(last_ver), "proto_ver");
      read_expect(`COMMS_GW_TYPE_ADDR, lb_data_t'(last_gw), "gw_type");
      read_expect(`COMMS_LOCATION_ADDR, lb_data_t'(last_loc), "location");
      read_expect(`COMMS_REV_ID_ADDR, lb_data_t'(last_rev), "rev_id");
   endtask

   task automatic crc_and_version_faults();
      send_frame(1'b1, `COMMS_PROTO_VER);
      lb_write(`COMMS_FAULT_CLR_ADDR, $urandom);
      wait_cycles(2);
      read_expect(`COMMS_FAULT_ADDR, 32'h0, "fault after clear");
      read_expect(`COMMS_FAULT_CNT_ADDR, 32'h0, "fault_cnt after clear");
      for (int i = 0; i < 3; i++)
         send_frame(1'b0, `COMMS_PROTO_VER);
      wait_cycles(2);
      read_expect(`COMMS_FAULT_ADDR, 32'h1, "fault after bad crc");
      read_expect(`COMMS_FAULT_CNT_ADDR, 32'h3, "fault_cnt after bad crc");
      send_frame(1'b1, `COMMS_PROTO_VER ^ 4'h1);
      wait_cycles(2);
      read_expect(`COMMS_FAULT_ADDR, 32'h3, "fault after version mismatch");
      lb_write(`COMMS_FAULT_CLR_ADDR, 32'h0);
      wait_cycles(2);
      read_expect(`COMMS_FAULT_ADDR, 32'h0, "fault after second clear");
      read_expect(`COMMS_FAULT_CNT_ADDR, 32'h0, "fault_cnt after second clear");
   endtask

   // Reply edge is d cycles after the marker edge
   task automatic marker_latency();
      pulse_marker();
      wait_cycles(17 - 2);
      send_frame(1'b1, `COMMS_PROTO_VER);
      wait_cycles(2);
      read_expect(`COMMS_LATENCY_ADDR, 32'd17, "latency");
      pulse_marker();
      send_frame(1'b0, `COMMS_PROTO_VER);
      wait_cycles(20 - 4);
      send_frame(1'b1, `COMMS_PROTO_VER);
      wait_cycles(2);
      read_expect(`COMMS_LATENCY_ADDR, 32'd20, "latency past bad frame");
   endtask

   task automatic tx_location_write();
      lb_data_t data;
      check_eq("tx_location_o", lb_data_t'(tx_location_o), 32'h0);
      for (int i = 0; i < 2; i++) begin
         data = $urandom;
         lb_write(`COMMS_TX_LOCATION_ADDR, data);
         @(negedge lb_clk);
         check_eq("tx_location_o", lb_data_t'(tx_location_o), lb_data_t'(data[2:0]));
      end
   endtask

   initial begin
      void'($urandom(32'h38ee_278c));
      reset_i            = 1'b1;
      lb_valid_i         = 1'b0;
      lb_rnw_i           = 1'b0;
      lb_addr_i          = '0;
      lb_wdata_i         = '0;
      rx_frame_valid_i   = 1'b0;
      rx_crc_ok_i        = 1'b0;
      rx_protocol_ver_i  = '0;
      rx_gateware_type_i = '0;
      rx_location_i      = '0;
      rx_rev_id_i        = '0;
      tx_marker_i        = 1'b0;
      exp_frames         = '0;
      repeat (4) @(posedge lb_clk);
      reset_i <= 1'b0;

      id_and_unmapped_reads();
      los_watchdog();
      frame_count_and_header();
      crc_and_version_faults();
      marker_latency();
      tx_location_write();

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
verilog/lb_pkg.sv
verilog/comms_pkg.sv
verilog/link_status_if.sv
verilog/rx_frame_monitor.sv
verilog/latency_meter.sv
verilog/comms_top_regbank.sv
verilog/comms_top.sv
verif/comms_top_assertions.sv
verif/comms_top_tb.sv

//--- Makefile
TOP = comms_top_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
